// ==== logic/qm_pkg.sv ====
package qm_pkg;

    // one pending request.
    typedef struct packed {
        logic [3:0] tag;
        logic [1:0] prio; // 3 is highest.
        logic [1:0] age;
    } q_entry_t;

    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_PUSH  = 2'd1,
        OP_POP   = 2'd2,
        OP_FLUSH = 2'd3
    } cmd_op_e;

    // command word.
    typedef struct packed {
        cmd_op_e  op;
        q_entry_t entry; // only used by a push.
    } cmd_t;

    localparam int ENTRY_W = $bits(q_entry_t);

    // entry promotes once its age has reached this.
    localparam logic [1:0] AGE_MAX = 2'd3;
    localparam logic [1:0] PRIO_MAX = 2'd3;

endpackage

// ==== logic/one_hot_mux.sv ====
`timescale 1ns/10ps

module one_hot_mux import qm_pkg::*; #(
    parameter int Q_LENGTH = 8
) (
    input  logic [Q_LENGTH*ENTRY_W-1:0] data_in,
    input  logic [Q_LENGTH-1:0]         sel,
    output q_entry_t                    data_out
);

    always_comb begin
        data_out = '0; // no select gives zero.
        for (int i = 0; i < Q_LENGTH; i++) begin
            if (sel[i]) begin
                data_out = q_entry_t'(data_in[i*ENTRY_W +: ENTRY_W]);
            end
        end
    end

    // two hot bits would silently pick the highest slot.
    always_comb begin
        if (!$isunknown(sel)) begin
            assert ($onehot0(sel))
                else $error("one_hot_mux: select not one-hot: %b", sel);
        end
    end

endmodule

// ==== logic/queue_manager.sv ====
`timescale 1ns/10ps

module queue_manager import qm_pkg::*; #(
    parameter int Q_LENGTH = 8,
    localparam int CNT_W = $clog2(Q_LENGTH + 1)
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  logic                        pop,
    input  logic                        flush,
    input  q_entry_t                    push_entry,
    input  logic [Q_LENGTH-1:0]         modify_mask,
    input  logic [Q_LENGTH*ENTRY_W-1:0] new_entries_flat,
    output logic [Q_LENGTH*ENTRY_W-1:0] entries_flat,
    output logic [Q_LENGTH-1:0]         valid_mask,
    output q_entry_t                    head_entry,
    output logic                        full,
    output logic                        empty,
    output logic [CNT_W-1:0]            count
);

    q_entry_t mem [Q_LENGTH];
    logic [Q_LENGTH-1:0] wr_ptr;
    logic [Q_LENGTH-1:0] rd_ptr;

    assign full = (count == CNT_W'(Q_LENGTH));
    assign empty = (count == '0);

    for (genvar k = 0; k < Q_LENGTH; k++) begin : g_flat
        assign entries_flat[k*ENTRY_W +: ENTRY_W] = mem[k];
    end

    one_hot_mux #(
        .Q_LENGTH(Q_LENGTH)
    ) head_mux_i (
        .data_in  (entries_flat),
        .sel      (rd_ptr),
        .data_out (head_entry)
    );

    // count slots starting at the read pointer.
    always_comb begin
        logic [Q_LENGTH-1:0] walk;
        walk = rd_ptr;
        valid_mask = '0;
        for (int k = 0; k < Q_LENGTH; k++) begin
            if (k < int'(count)) begin
                valid_mask = valid_mask | walk;
            end
            walk = {walk[Q_LENGTH-2:0], walk[Q_LENGTH-1]};
        end
    end

    // write-back first, so a push into the same slot wins.
    always_ff @(posedge clk) begin
        for (int i = 0; i < Q_LENGTH; i++) begin
            if (modify_mask[i]) begin
                mem[i] <= q_entry_t'(new_entries_flat[i*ENTRY_W +: ENTRY_W]);
            end
        end
        if (push) begin
            for (int i = 0; i < Q_LENGTH; i++) begin
                if (wr_ptr[i]) begin
                    mem[i] <= push_entry;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= Q_LENGTH'(1);
            rd_ptr <= Q_LENGTH'(1);
            count <= '0;
        end else if (flush) begin
            wr_ptr <= Q_LENGTH'(1); // contents stay, only pointers reset.
            rd_ptr <= Q_LENGTH'(1);
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= {wr_ptr[Q_LENGTH-2:0], wr_ptr[Q_LENGTH-1]};
            end
            if (pop) begin
                rd_ptr <= {rd_ptr[Q_LENGTH-2:0], rd_ptr[Q_LENGTH-1]};
            end
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    a_ptr_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot(wr_ptr) && $onehot(rd_ptr))
        else $error("queue_manager: pointer lost one-hot state");

    // the decoder is expected to filter these out.
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        push |-> !full)
        else $error("queue_manager: push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty)
        else $error("queue_manager: pop while empty");

endmodule

// ==== logic/aging_unit.sv ====
`timescale 1ns/10ps

module aging_unit import qm_pkg::*; #(
    parameter int Q_LENGTH = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        age_tick,
    input  logic [Q_LENGTH*ENTRY_W-1:0] entries_flat,
    input  logic [Q_LENGTH-1:0]         valid_mask,
    output logic [Q_LENGTH-1:0]         modify_mask,
    output logic [Q_LENGTH*ENTRY_W-1:0] new_entries_flat
);

    logic [Q_LENGTH*ENTRY_W-1:0] aged_flat;

    // age up, or wrap age and promote.
    always_comb begin
        q_entry_t cur;
        q_entry_t nxt;
        for (int i = 0; i < Q_LENGTH; i++) begin
            cur = q_entry_t'(entries_flat[i*ENTRY_W +: ENTRY_W]);
            nxt = cur;
            if (cur.age < AGE_MAX) begin
                nxt.age = cur.age + 2'd1;
            end else begin
                nxt.age = 2'd0;
                if (cur.prio != PRIO_MAX) begin
                    nxt.prio = cur.prio + 2'd1;
                end
            end
            aged_flat[i*ENTRY_W +: ENTRY_W] = nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            modify_mask <= '0;
        end else begin
            modify_mask <= age_tick ? valid_mask : '0; // empty slots never touched.
        end
    end

    always_ff @(posedge clk) begin
        new_entries_flat <= aged_flat;
    end

    a_mask_subset: assert property (@(posedge clk) disable iff (rst)
        (modify_mask & ~$past(valid_mask)) == '0)
        else $error("aging_unit: write-back to a slot that was not valid");

    a_mask_idle: assert property (@(posedge clk) disable iff (rst)
        !age_tick |=> modify_mask == '0)
        else $error("aging_unit: write-back without a tick");

endmodule

// ==== logic/cmd_decoder.sv ====
`timescale 1ns/10ps

module cmd_decoder import qm_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cmd_valid,
    input  cmd_t       cmd,
    input  logic       full,
    input  logic       empty,
    input  q_entry_t   head_entry,
    output logic       push,
    output logic       pop,
    output logic       flush,
    output q_entry_t   push_entry,
    output logic       out_valid,
    output q_entry_t   out_entry,
    output logic [7:0] drop_count
);

    logic drop;

    assign push = cmd_valid && (cmd.op == OP_PUSH) && !full;
    assign pop = cmd_valid && (cmd.op == OP_POP) && !empty;
    assign flush = cmd_valid && (cmd.op == OP_FLUSH);
    assign push_entry = cmd.entry;

    // push into full or pop from empty.
    assign drop = cmd_valid && (((cmd.op == OP_PUSH) && full) ||
                                ((cmd.op == OP_POP) && empty));

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            drop_count <= '0;
        end else begin
            out_valid <= pop;
            if (drop && (drop_count != 8'hff)) begin
                drop_count <= drop_count + 8'd1; // saturates.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_entry <= head_entry;
        end
    end

    // each output pulse belongs to exactly one pop.
    a_single_pulse: assert property (@(posedge clk) disable iff (rst)
        out_valid && !pop |=> !out_valid)
        else $error("cmd_decoder: out_valid held without a new pop");

endmodule

// ==== logic/qm_top.sv ====
`timescale 1ns/10ps

module qm_top import qm_pkg::*; #(
    parameter int Q_LENGTH = 8,
    localparam int CNT_W = $clog2(Q_LENGTH + 1)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cmd_valid,
    input  cmd_t             cmd,
    input  logic             age_tick,
    output logic             out_valid,
    output q_entry_t         out_entry,
    output logic             full,
    output logic             empty,
    output logic [CNT_W-1:0] count,
    output logic [7:0]       drop_count
);

    logic push;
    logic pop;
    logic flush;
    q_entry_t push_entry;
    q_entry_t head_entry;
    logic [Q_LENGTH-1:0] valid_mask;
    logic [Q_LENGTH-1:0] modify_mask;
    logic [Q_LENGTH*ENTRY_W-1:0] entries_flat;
    logic [Q_LENGTH*ENTRY_W-1:0] new_entries_flat;

    cmd_decoder decoder_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .full       (full),
        .empty      (empty),
        .head_entry (head_entry),
        .push       (push),
        .pop        (pop),
        .flush      (flush),
        .push_entry (push_entry),
        .out_valid  (out_valid),
        .out_entry  (out_entry),
        .drop_count (drop_count)
    );

    queue_manager #(
        .Q_LENGTH(Q_LENGTH)
    ) queue_i (
        .clk              (clk),
        .rst              (rst),
        .push             (push),
        .pop              (pop),
        .flush            (flush),
        .push_entry       (push_entry),
        .modify_mask      (modify_mask),
        .new_entries_flat (new_entries_flat),
        .entries_flat     (entries_flat),
        .valid_mask       (valid_mask),
        .head_entry       (head_entry),
        .full             (full),
        .empty            (empty),
        .count            (count)
    );

    aging_unit #(
        .Q_LENGTH(Q_LENGTH)
    ) aging_i (
        .clk              (clk),
        .rst              (rst),
        .age_tick         (age_tick),
        .entries_flat     (entries_flat),
        .valid_mask       (valid_mask),
        .modify_mask      (modify_mask),
        .new_entries_flat (new_entries_flat)
    );

endmodule

// ==== verification/qm_tb.sv ====
`timescale 1ns/10ps

module qm_tb import qm_pkg::*; ();

    localparam int Q_LENGTH = 8;
    localparam int CNT_W = $clog2(Q_LENGTH + 1);
    localparam int CLK_PERIOD = 100;

    // rough cycles per test from 3 per push, 4 per pop and 3 per tick.
    localparam int T_RESET = 4 + 5;
    localparam int T_FIFO = 5 * 3 + 5 * 4;
    localparam int T_LIMITS = 9 * 3 + 9 * 4;
    localparam int T_AGING = 3 * 3 + 10 * 3 + 3 * 4;
    localparam int T_WRAP = 11 * 3 + 11 * 4 + 3;
    localparam int T_FLUSH = 7 * 3 + 4 * 4 + 3;
    localparam int WATCHDOG_CYCLES = T_RESET + T_FIFO + T_LIMITS + T_AGING + T_WRAP + T_FLUSH + 50;

    logic clk;
    logic rst;
    logic cmd_valid;
    cmd_t cmd;
    logic age_tick;
    logic out_valid;
    q_entry_t out_entry;
    logic full;
    logic empty;
    logic [CNT_W-1:0] count;
    logic [7:0] drop_count;

    q_entry_t model_q[$]; // valid entries, head first.
    int exp_drops = 0;
    int seed = 18;
    int checks = 0;
    int errors = 0;
    int tests_run = 0;
    string test_name = "none";

    qm_top #(
        .Q_LENGTH(Q_LENGTH)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .age_tick   (age_tick),
        .out_valid  (out_valid),
        .out_entry  (out_entry),
        .full       (full),
        .empty      (empty),
        .count      (count),
        .drop_count (drop_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout, the tests did not finish in the expected time");
        $display("Checks failed");
        $finish;
    end

    // age counts up to the limit and then wraps and promotes.
    function automatic q_entry_t aged(input q_entry_t e);
        q_entry_t r;
        int a;
        int p;
        r = e;
        a = int'(e.age);
        p = int'(e.prio);
        if (a < int'(AGE_MAX)) begin
            a = a + 1;
        end else begin
            a = 0;
            p = (p + 1 > int'(PRIO_MAX)) ? int'(PRIO_MAX) : p + 1;
        end
        r.age = 2'(a);
        r.prio = 2'(p);
        return r;
    endfunction

    function automatic q_entry_t rand_entry();
        logic [31:0] r;
        r = $random(seed);
        return q_entry_t'(r[7:0]);
    endfunction

    task automatic check_val(input string what, input int expected, input int actual);
        checks++;
        assert (expected == actual)
            else begin
                $display("Fail %s: %s expected %0h actual %0h", test_name, what, expected,
                         actual);
                errors++;
            end
    endtask

    task automatic check_state();
        check_val("count", model_q.size(), int'(count));
        check_val("full", int'(model_q.size() == Q_LENGTH), int'(full));
        check_val("empty", int'(model_q.size() == 0), int'(empty));
        check_val("drop_count", exp_drops, int'(drop_count));
    endtask

    task automatic send_cmd(input cmd_op_e op, input q_entry_t e);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd.op <= op;
        cmd.entry <= e;
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic push_op(input q_entry_t e);
        bit accept;
        accept = (model_q.size() < Q_LENGTH);
        send_cmd(OP_PUSH, e);
        @(negedge clk);
        if (accept) begin
            model_q.push_back(e);
        end else begin
            exp_drops++;
        end
        check_state();
    endtask

    // output is latched at the pop edge and lives for one cycle.
    task automatic pop_op();
        q_entry_t exp_e;
        bit legal;
        legal = (model_q.size() > 0);
        send_cmd(OP_POP, '0);
        @(negedge clk);
        if (legal) begin
            exp_e = model_q.pop_front();
            check_val("out_valid", 1, int'(out_valid));
            check_val("out_entry", int'(exp_e), int'(out_entry));
        end else begin
            exp_drops++;
            check_val("out_valid on dropped pop", 0, int'(out_valid));
        end
        check_state();
        @(negedge clk);
        check_val("out_valid after pulse", 0, int'(out_valid));
    endtask

    task automatic flush_op();
        send_cmd(OP_FLUSH, '0);
        @(negedge clk);
        model_q.delete();
        check_state();
    endtask

    task automatic tick_op();
        @(posedge clk);
        age_tick <= 1'b1;
        @(posedge clk);
        age_tick <= 1'b0;
        foreach (model_q[i]) begin
            model_q[i] = aged(model_q[i]);
        end
        @(posedge clk); // write-back lands here.
    endtask

    task automatic end_test(input int errs_before);
        tests_run++;
        $display("test %s finished with %0d errors", test_name, errors - errs_before);
    endtask

    task automatic reset_state_test();
        int e0;
        test_name = "reset_state";
        e0 = errors;
        repeat (3) begin
            @(negedge clk);
            check_state();
            check_val("out_valid", 0, int'(out_valid));
        end
        end_test(e0);
    endtask

    task automatic fifo_order_test();
        int e0;
        test_name = "fifo_order";
        e0 = errors;
        repeat (5) push_op(rand_entry());
        repeat (5) pop_op();
        end_test(e0);
    endtask

    task automatic limits_test();
        int e0;
        test_name = "full_empty_limits";
        e0 = errors;
        repeat (Q_LENGTH + 1) push_op(rand_entry()); // last one is dropped.
        repeat (Q_LENGTH + 1) pop_op();
        end_test(e0);
    endtask

    task automatic aging_test();
        int e0;
        q_entry_t e;
        test_name = "aging_promotion";
        e0 = errors;
        for (int p = 0; p < 3; p++) begin
            e = rand_entry();
            e.prio = 2'(p == 0 ? 0 : p + 1); // prio 0, 2 and 3.
            e.age = 2'(p + 1);
            push_op(e);
        end
        repeat (10) tick_op();
        repeat (3) pop_op();
        end_test(e0);
    endtask

    task automatic wrap_test();
        int e0;
        test_name = "partial_aging_wrap";
        e0 = errors;
        repeat (6) push_op(rand_entry());
        repeat (6) pop_op();
        repeat (4) push_op(rand_entry()); // pointers wrap past slot 7.
        tick_op();
        push_op(rand_entry());
        repeat (5) pop_op();
        end_test(e0);
    endtask

    task automatic flush_test();
        int e0;
        test_name = "flush";
        e0 = errors;
        repeat (4) push_op(rand_entry());
        flush_op();
        pop_op();
        repeat (3) push_op(rand_entry());
        repeat (3) pop_op();
        end_test(e0);
    endtask

    initial begin
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd = '0;
        age_tick = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        reset_state_test();
        fifo_order_test();
        limits_test();
        aging_test();
        wrap_test();
        flush_test();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== qm_subsys.f ====
logic/qm_pkg.sv
logic/one_hot_mux.sv
logic/queue_manager.sv
logic/aging_unit.sv
logic/cmd_decoder.sv
logic/qm_top.sv
verification/qm_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps --top-module qm_tb \
    -f qm_subsys.f -o qm_sim > build.log 2>&1 \
    || { cat build.log; echo "Checks failed" > sim.log; }
[ -f sim.log ] || ./obj_dir/qm_sim > sim.log 2>&1 || echo "Checks failed" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
